//--- tb.f
src/lsu_pkg.sv
src/agu_stage.sv
src/mem_stage.sv
src/data_ram.sv
src/wb_stage.sv
src/lsu_top.sv
sim/tb_lsu.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Compile and run the LSU testbench with Verilator.
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal --top-module tb_lsu -f tb.f -o vtb_lsu
if [ $? -ne 0 ]; then
  echo "compile failed"
  exit 1
fi

out=$(./obj_dir/vtb_lsu)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if echo "$out" | grep -qx "PASS: all tests"; then
  exit 0
fi
exit 1

//--- sim/tb_lsu.sv
`timescale 1ns/100ps

module tb_lsu;

  import lsu_pkg::*;

  // about 256 operations at up to 7 cycles each, plus reset and idle checks.
  localparam int n_ops      = 256;
  localparam int worst_lat  = 7;
  localparam int max_cycles = n_ops * worst_lat + 208;

  typedef struct packed {
    logic [4:0]      rd;
    logic            we;
    logic            chk;
    logic [xlen-1:0] data;
  } exp_t;

  logic            clk;
  logic            rst;
  logic            issue_valid;
  mem_op_e         issue_op;
  logic [4:0]      issue_rd;
  logic [xlen-1:0] issue_base;
  logic [xlen-1:0] issue_offset;
  logic [xlen-1:0] issue_wdata;
  logic            issue_allowin;
  logic            retire_valid;
  logic            retire_we;
  logic [4:0]      retire_rd;
  logic [xlen-1:0] retire_data;

  logic [7:0]  ref_mem [0:2047];
  exp_t        exp_q [$];
  int          errors;
  int          checks;
  int          tests_run;
  int          tests_failed;
  int          cycles;
  bit          stall_seen;

  lsu_top u_dut (
    .clk          (clk),
    .rst          (rst),
    .issue_valid  (issue_valid),
    .issue_op     (issue_op),
    .issue_rd     (issue_rd),
    .issue_base   (issue_base),
    .issue_offset (issue_offset),
    .issue_wdata  (issue_wdata),
    .issue_allowin(issue_allowin),
    .retire_valid (retire_valid),
    .retire_we    (retire_we),
    .retire_rd    (retire_rd),
    .retire_data  (retire_data)
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  // ********************
  // reference model
  // ********************

  function automatic int unsigned op_bytes(mem_op_e op);
    case (op)
      op_lb, op_lbu, op_sb: return 1;
      op_lh, op_lhu, op_sh: return 2;
      op_lw, op_lwu, op_sw: return 4;
      default:              return 8;
    endcase
  endfunction

  function automatic bit is_store_op(mem_op_e op);
    return op inside {op_sb, op_sh, op_sw, op_sd};
  endfunction

  function automatic bit is_signed_load(mem_op_e op);
    return op inside {op_lb, op_lh, op_lw, op_ld};
  endfunction

  // bytes are little endian and those above the access copy its top bit.
  function automatic logic [xlen-1:0] ref_read(logic [xlen-1:0] addr, int unsigned n, bit sgn);
    logic [xlen-1:0] v;
    logic            fill;
    v = '0;
    for (int i = 0; i < int'(n); i++) begin
      v[8*i +: 8] = ref_mem[addr[10:0] + 11'(i)];
    end
    fill = sgn && v[8*n-1];
    for (int i = 8 * int'(n); i < xlen; i++) begin
      v[i] = fill;
    end
    return v;
  endfunction

  task automatic ref_write(logic [xlen-1:0] addr, int unsigned n, logic [xlen-1:0] wdata);
    for (int i = 0; i < int'(n); i++) begin
      ref_mem[addr[10:0] + 11'(i)] = wdata[8*i +: 8];
    end
  endtask

  // ********************
  // drivers and checks
  // ********************

  task automatic report_error(string msg);
    $display("[FAIL] t=%0t %s", $time, msg);
    errors++;
  endtask

  // called at a falling edge, returns at the falling edge after acceptance.
  task automatic send(mem_op_e op, logic [4:0] rd, logic [xlen-1:0] base,
                      logic [xlen-1:0] offset, logic [xlen-1:0] wdata);
    exp_t            e;
    logic [xlen-1:0] addr;
    int unsigned     n;
    addr   = base + offset;
    n      = op_bytes(op);
    e.rd   = rd;
    e.we   = !is_store_op(op);
    e.chk  = 1'b1;
    e.data = addr;
    if (is_store_op(op)) begin
      e.chk = 1'b0;
      ref_write(addr, n, wdata);
    end else if (op != op_addr) begin
      e.data = ref_read(addr, n, is_signed_load(op));
    end
    issue_valid  = 1'b1;
    issue_op     = op;
    issue_rd     = rd;
    issue_base   = base;
    issue_offset = offset;
    issue_wdata  = wdata;
    while (!issue_allowin) begin
      stall_seen = 1'b1;
      @(negedge clk);
    end
    exp_q.push_back(e);
    @(negedge clk);
    issue_valid = 1'b0;
  endtask

  task automatic drain();
    while (exp_q.size() != 0) begin
      @(negedge clk);
    end
    // a few idle cycles to catch a stray retire.
    repeat (4) @(negedge clk);
  endtask

  task automatic close_test(string name, int err_before);
    tests_run++;
    if (errors != err_before) begin
      tests_failed++;
      $display("test %s: %0d errors", name, errors - err_before);
    end else begin
      $display("test %s: ok", name);
    end
  endtask

  // results leave the retire port in issue order.
  always @(negedge clk) begin : collect
    exp_t e;
    if (!rst && retire_valid) begin
      if (exp_q.size() == 0) begin
        $display("error at %0t: retire with no operation outstanding", $time);
        errors++;
      end else begin
        e = exp_q.pop_front();
        checks++;
        if (retire_rd !== e.rd) begin
          report_error($sformatf("retire_rd got %0d, expected %0d", retire_rd, e.rd));
        end
        if (retire_we !== e.we) begin
          report_error($sformatf("retire_we got %0b, expected %0b", retire_we, e.we));
        end
        if (e.chk && retire_data !== e.data) begin
          report_error($sformatf("retire_data got %h, expected %h", retire_data, e.data));
        end
      end
    end
  end

  // ********************
  // tests
  // ********************

  task automatic test_reset_idle();
    int err_before;
    err_before = errors;
    repeat (6) begin
      if (issue_allowin !== 1'b1) begin
        report_error("issue_allowin not high after reset");
      end
      if (retire_valid !== 1'b0) begin
        report_error("retire_valid not low after reset");
      end
      @(negedge clk);
    end
    close_test("reset_idle", err_before);
  endtask

  task automatic test_store_load();
    int              err_before;
    logic [xlen-1:0] addr;
    logic [xlen-1:0] pattern;
    mem_op_e         st_ops [4];
    mem_op_e         ld_ops [7];
    err_before = errors;
    st_ops  = '{op_sb, op_sh, op_sw, op_sd};
    ld_ops  = '{op_lb, op_lh, op_lw, op_ld, op_lbu, op_lhu, op_lwu};
    pattern = 64'hf0e1_d2c3_b4a5_9687;
    for (int k = 0; k < 4; k++) begin
      addr = 64'h100 + 64'(k * 16);
      // a positive background shows the masking in wider loads.
      send(op_sd, 5'd1, addr, 64'd0, 64'h1122_3344_5566_7788);
      send(st_ops[k], 5'd2, addr + 64'd16, -64'd16, pattern);
      for (int j = 0; j < 7; j++) begin
        send(ld_ops[j], 5'(j + 3), addr - 64'd8, 64'd8, 64'd0);
      end
    end
    drain();
    close_test("store_load", err_before);
  endtask

  task automatic test_addr_latency();
    int              err_before;
    int              lat;
    logic [xlen-1:0] base;
    logic [xlen-1:0] offset;
    err_before = errors;
    for (int i = 0; i < 4; i++) begin
      base   = {$urandom, $urandom};
      offset = {$urandom, $urandom};
      send(op_addr, 5'(i + 10), base, offset, 64'd0);
      lat = 1;
      while (!retire_valid && lat < 8) begin
        @(negedge clk);
        lat++;
      end
      if (!retire_valid || lat != 3) begin
        report_error($sformatf("op_addr retired after %0d cycles, expected 3", lat));
      end
      @(negedge clk);
    end
    drain();
    close_test("addr_latency", err_before);
  endtask

  task automatic test_stream();
    int err_before;
    err_before = errors;
    stall_seen = 1'b0;
    send(op_sd, 5'd1, 64'h200, 64'd0, 64'h8899_aabb_ccdd_eeff);
    send(op_addr, 5'd2, 64'h1000, 64'd44, 64'd0);
    send(op_ld, 5'd3, 64'h1f8, 64'd8, 64'd0);
    send(op_lw, 5'd4, 64'h204, 64'd0, 64'd0);
    send(op_sb, 5'd5, 64'h201, 64'd0, 64'h0000_0000_0000_0081);
    send(op_lbu, 5'd6, 64'h201, 64'd0, 64'd0);
    send(op_lb, 5'd7, 64'h202, -64'd1, 64'd0);
    send(op_addr, 5'd8, 64'hffff_ffff_ffff_fff0, 64'h20, 64'd0);
    send(op_sh, 5'd9, 64'h206, 64'd0, 64'h0000_0000_0000_9abc);
    send(op_lh, 5'd10, 64'h206, 64'd0, 64'd0);
    send(op_lhu, 5'd11, 64'h206, 64'd0, 64'd0);
    send(op_sw, 5'd12, 64'h208, 64'd0, 64'h0000_0000_cafe_f00d);
    send(op_lwu, 5'd13, 64'h208, 64'd0, 64'd0);
    send(op_lw, 5'd14, 64'h208, 64'd0, 64'd0);
    send(op_addr, 5'd15, 64'h300, 64'd8, 64'd0);
    send(op_ld, 5'd16, 64'h200, 64'd0, 64'd0);
    drain();
    if (!stall_seen) begin
      $display("error at %0t: issue_allowin never went low during the stream", $time);
      errors++;
    end
    close_test("stream", err_before);
  endtask

  task automatic test_random();
    int              err_before;
    mem_op_e         op;
    int unsigned     n;
    logic [xlen-1:0] addr;
    logic [xlen-1:0] offset;
    err_before = errors;
    for (int i = 0; i < 200; i++) begin
      op     = mem_op_e'(4'($urandom % 12));
      n      = op_bytes(op);
      // 32 words keep loads hitting earlier stores.
      addr   = 64'h400 + 64'(($urandom % 32) * 8) + 64'(($urandom % (8 / n)) * n);
      offset = 64'($urandom % 128) - 64'd64;
      send(op, 5'($urandom), addr - offset, offset, {$urandom, $urandom});
    end
    drain();
    close_test("random", err_before);
  endtask

  // ********************
  // main sequence
  // ********************

  initial begin
    errors       = 0;
    checks       = 0;
    tests_run    = 0;
    tests_failed = 0;
    stall_seen   = 1'b0;
    void'($urandom(57));
    rst          = 1'b1;
    issue_valid  = 1'b0;
    issue_op     = op_addr;
    issue_rd     = '0;
    issue_base   = '0;
    issue_offset = '0;
    issue_wdata  = '0;
    for (int i = 0; i < 2048; i++) begin
      ref_mem[i] = 8'h00;
    end
    repeat (5) @(negedge clk);
    rst = 1'b0;

    test_reset_idle();
    test_store_load();
    test_addr_latency();
    test_stream();
    test_random();

    $display("tests run %0d, tests with errors %0d, checks %0d, errors %0d",
             tests_run, tests_failed, checks, errors);
    if (errors == 0) begin
      $display("PASS: all tests");
    end else begin
      $display("FAIL: see errors above");
    end
    $finish;
  end

  initial begin
    cycles = 0;
    while (cycles < max_cycles) begin
      @(posedge clk);
      cycles++;
    end
    $display("timeout: run reached %0d cycles without finishing", max_cycles);
    $display("FAIL: see errors above");
    $finish;
  end

endmodule

//--- src/lsu_top.sv
`timescale 1ns/100ps

module lsu_top #(
  parameter int ram_depth   = 256,
  parameter int ram_latency = 2
) (
  input  logic                       clk,
  input  logic                       rst,
  input  logic                       issue_valid,
  input  lsu_pkg::mem_op_e           issue_op,
  input  logic [4:0]                 issue_rd,
  input  logic [lsu_pkg::xlen-1:0]   issue_base,
  input  logic [lsu_pkg::xlen-1:0]   issue_offset,
  input  logic [lsu_pkg::xlen-1:0]   issue_wdata,
  output logic                       issue_allowin,
  output logic                       retire_valid,
  output logic                       retire_we,
  output logic [4:0]                 retire_rd,
  output logic [lsu_pkg::xlen-1:0]   retire_data
);

  import lsu_pkg::*;

  // ********************
  // stage links
  // ********************

  logic            agu_valid;
  mem_op_e         agu_op;
  logic [4:0]      agu_rd;
  logic [xlen-1:0] agu_addr;
  logic [xlen-1:0] agu_wdata;
  logic            mem_allowin;

  logic            mem_valid;
  logic [4:0]      mem_rd;
  logic            mem_we;
  logic [xlen-1:0] mem_data;
  logic            wb_allowin;

  // memory port.
  logic            rw_valid;
  logic            rw_write;
  logic [xlen-1:0] rw_addr;
  mem_size_e       rw_size;
  logic [xlen-1:0] rw_wdata;
  logic            rw_ready;
  logic [xlen-1:0] rw_rdata;

  agu_stage u_agu (
    .clk          (clk),
    .rst          (rst),
    .issue_valid  (issue_valid),
    .issue_op     (issue_op),
    .issue_rd     (issue_rd),
    .issue_base   (issue_base),
    .issue_offset (issue_offset),
    .issue_wdata  (issue_wdata),
    .issue_allowin(issue_allowin),
    .agu_valid    (agu_valid),
    .agu_op       (agu_op),
    .agu_rd       (agu_rd),
    .agu_addr     (agu_addr),
    .agu_wdata    (agu_wdata),
    .mem_allowin  (mem_allowin)
  );

  mem_stage u_mem (
    .clk        (clk),
    .rst        (rst),
    .agu_valid  (agu_valid),
    .agu_op     (agu_op),
    .agu_rd     (agu_rd),
    .agu_addr   (agu_addr),
    .agu_wdata  (agu_wdata),
    .mem_allowin(mem_allowin),
    .mem_valid  (mem_valid),
    .mem_rd     (mem_rd),
    .mem_we     (mem_we),
    .mem_data   (mem_data),
    .wb_allowin (wb_allowin),
    .rw_valid   (rw_valid),
    .rw_write   (rw_write),
    .rw_addr    (rw_addr),
    .rw_size    (rw_size),
    .rw_wdata   (rw_wdata),
    .rw_ready   (rw_ready),
    .rw_rdata   (rw_rdata)
  );

  wb_stage u_wb (
    .clk         (clk),
    .rst         (rst),
    .mem_valid   (mem_valid),
    .mem_rd      (mem_rd),
    .mem_we      (mem_we),
    .mem_data    (mem_data),
    .wb_allowin  (wb_allowin),
    .retire_valid(retire_valid),
    .retire_rd   (retire_rd),
    .retire_we   (retire_we),
    .retire_data (retire_data)
  );

  data_ram #(
    .ram_depth  (ram_depth),
    .ram_latency(ram_latency)
  ) u_ram (
    .clk     (clk),
    .rst     (rst),
    .rw_valid(rw_valid),
    .rw_write(rw_write),
    .rw_addr (rw_addr),
    .rw_size (rw_size),
    .rw_wdata(rw_wdata),
    .rw_ready(rw_ready),
    .rw_rdata(rw_rdata)
  );

endmodule

//--- src/wb_stage.sv
`timescale 1ns/100ps

module wb_stage (
  input  logic                       clk,
  input  logic                       rst,

  input  logic                       mem_valid,
  input  logic [4:0]                 mem_rd,
  input  logic                       mem_we,
  input  logic [lsu_pkg::xlen-1:0]   mem_data,
  output logic                       wb_allowin,

  output logic                       retire_valid,
  output logic [4:0]                 retire_rd,
  output logic                       retire_we,
  output logic [lsu_pkg::xlen-1:0]   retire_data
);

  import lsu_pkg::*;

  logic            valid_q;
  logic            accept;
  logic [4:0]      rd_q;
  logic            we_q;
  logic [xlen-1:0] data_q;

  // drains every cycle.
  assign wb_allowin = 1'b1;
  assign accept     = mem_valid && wb_allowin;

  always_ff @(posedge clk) begin
    if (rst) begin
      valid_q <= 1'b0;
    end else begin
      valid_q <= accept;
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      rd_q   <= mem_rd;
      we_q   <= mem_we;
      data_q <= mem_data;
    end
  end

  assign retire_valid = valid_q;
  assign retire_rd    = rd_q;
  assign retire_we    = we_q;
  assign retire_data  = data_q;

endmodule

//--- src/data_ram.sv
`timescale 1ns/100ps

module data_ram #(
  parameter int ram_depth   = 256,
  parameter int ram_latency = 2
) (
  input  logic                       clk,
  input  logic                       rst,
  input  logic                       rw_valid,
  input  logic                       rw_write,
  input  logic [lsu_pkg::xlen-1:0]   rw_addr,
  input  lsu_pkg::mem_size_e         rw_size,
  input  logic [lsu_pkg::xlen-1:0]   rw_wdata,
  output logic                       rw_ready,
  output logic [lsu_pkg::xlen-1:0]   rw_rdata
);

  import lsu_pkg::*;

  localparam int aw    = $clog2(ram_depth);
  localparam int cnt_w = $clog2(ram_latency + 1);

  ram_word_u        mem [0:ram_depth-1];
  logic [cnt_w-1:0] cnt;
  logic [aw-1:0]    idx;
  logic [2:0]       off;
  ram_word_u        cur;
  ram_word_u        wr_word;

  // cycles of rw_valid seen so far for the pending request.
  always_ff @(posedge clk) begin
    if (rst) begin
      cnt <= '0;
    end else if (rw_valid && rw_ready) begin
      cnt <= '0;
    end else if (rw_valid) begin
      cnt <= cnt + 1'b1;
    end
  end

  assign rw_ready = rw_valid && (cnt == cnt_w'(ram_latency));

  assign idx = rw_addr[3 +: aw];
  assign off = rw_addr[2:0];
  assign cur = mem[idx];

  // merge right-aligned store data into the addressed lanes.
  always_comb begin
    wr_word = cur;
    case (rw_size)
      size_b:  wr_word.b[off]      = rw_wdata[7:0];
      size_h:  wr_word.h[off[2:1]] = rw_wdata[15:0];
      size_w:  wr_word.w[off[2]]   = rw_wdata[31:0];
      default: wr_word.d           = rw_wdata;
    endcase
  end

  always_comb begin
    case (rw_size)
      size_b:  rw_rdata = {{(xlen-8){1'b0}}, cur.b[off]};
      size_h:  rw_rdata = {{(xlen-16){1'b0}}, cur.h[off[2:1]]};
      size_w:  rw_rdata = {{(xlen-32){1'b0}}, cur.w[off[2]]};
      default: rw_rdata = cur.d;
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < ram_depth; i++) begin
        mem[i] <= '0;
      end
    end else if (rw_valid && rw_ready && rw_write) begin
      mem[idx] <= wr_word;
    end
  end

endmodule

//--- src/mem_stage.sv
`timescale 1ns/100ps

module mem_stage (
  input  logic                       clk,
  input  logic                       rst,

  input  logic                       agu_valid,
  input  lsu_pkg::mem_op_e           agu_op,
  input  logic [4:0]                 agu_rd,
  input  logic [lsu_pkg::xlen-1:0]   agu_addr,
  input  logic [lsu_pkg::xlen-1:0]   agu_wdata,
  output logic                       mem_allowin,

  output logic                       mem_valid,
  output logic [4:0]                 mem_rd,
  output logic                       mem_we,
  output logic [lsu_pkg::xlen-1:0]   mem_data,
  input  logic                       wb_allowin,

  output logic                       rw_valid,
  output logic                       rw_write,
  output logic [lsu_pkg::xlen-1:0]   rw_addr,
  output lsu_pkg::mem_size_e         rw_size,
  output logic [lsu_pkg::xlen-1:0]   rw_wdata,
  input  logic                       rw_ready,
  input  logic [lsu_pkg::xlen-1:0]   rw_rdata
);

  import lsu_pkg::*;

  localparam logic [1:0] st_idle = 2'd0;
  localparam logic [1:0] st_addr = 2'd1;
  localparam logic [1:0] st_retn = 2'd2;

  logic            valid_q;
  mem_op_e         op_q;
  logic [4:0]      rd_q;
  logic [xlen-1:0] addr_q;
  logic [xlen-1:0] wdata_q;
  logic [1:0]      state;
  logic [1:0]      next_state;
  logic            ready_go;
  logic            refresh;
  logic            in_mem;
  logic            is_mem;
  logic            is_store;
  logic            rw_hs;
  mem_size_e       size;
  logic [xlen-1:0] load_q;
  logic [xlen-1:0] load_ext;
  ram_word_u       rd_word;

  // ********************
  // pipeline control
  // ********************

  assign is_mem      = op_q != op_addr;
  assign in_mem      = agu_op != op_addr;
  assign ready_go    = is_mem ? (state == st_retn) : 1'b1;
  assign mem_allowin = !valid_q || (ready_go && wb_allowin);
  assign refresh     = agu_valid && mem_allowin;
  assign mem_valid   = valid_q && ready_go;

  always_ff @(posedge clk) begin
    if (rst) begin
      valid_q <= 1'b0;
    end else if (mem_allowin) begin
      valid_q <= agu_valid;
    end
  end

  always_ff @(posedge clk) begin
    if (refresh) begin
      op_q    <= agu_op;
      rd_q    <= agu_rd;
      addr_q  <= agu_addr;
      wdata_q <= agu_wdata;
    end
  end

  // ********************
  // request fsm
  // ********************

  assign rw_hs = rw_valid && rw_ready;

  always_ff @(posedge clk) begin
    if (rst) begin
      state <= st_idle;
    end else begin
      state <= next_state;
    end
  end

  always_comb begin
    next_state = state;
    case (state)
      st_idle: if (refresh && in_mem) next_state = st_addr;
      st_addr: if (rw_hs) next_state = st_retn;
      // leaving return, a new memory item goes straight to addr.
      st_retn: if (mem_allowin) next_state = (refresh && in_mem) ? st_addr : st_idle;
      default: next_state = st_idle;
    endcase
  end

  // ********************
  // decode and data path
  // ********************

  always_comb begin
    case (op_q)
      op_lb, op_lbu, op_sb: size = size_b;
      op_lh, op_lhu, op_sh: size = size_h;
      op_lw, op_lwu, op_sw: size = size_w;
      default:              size = size_d;
    endcase
  end

  assign is_store = (op_q == op_sb) || (op_q == op_sh) || (op_q == op_sw) || (op_q == op_sd);

  assign rw_valid = state == st_addr;
  assign rw_write = is_store;
  assign rw_addr  = addr_q;
  assign rw_size  = size;

  always_comb begin
    case (size)
      size_b:  rw_wdata = {{(xlen-8){1'b0}}, wdata_q[7:0]};
      size_h:  rw_wdata = {{(xlen-16){1'b0}}, wdata_q[15:0]};
      size_w:  rw_wdata = {{(xlen-32){1'b0}}, wdata_q[31:0]};
      default: rw_wdata = wdata_q;
    endcase
  end

  // read data arrives right-aligned, so lane 0 of each view.
  assign rd_word = rw_rdata;

  always_comb begin
    case (op_q)
      op_lb:   load_ext = {{(xlen-8){rd_word.b[0][7]}}, rd_word.b[0]};
      op_lh:   load_ext = {{(xlen-16){rd_word.h[0][15]}}, rd_word.h[0]};
      op_lw:   load_ext = {{(xlen-32){rd_word.w[0][31]}}, rd_word.w[0]};
      op_lbu:  load_ext = {{(xlen-8){1'b0}}, rd_word.b[0]};
      op_lhu:  load_ext = {{(xlen-16){1'b0}}, rd_word.h[0]};
      op_lwu:  load_ext = {{(xlen-32){1'b0}}, rd_word.w[0]};
      default: load_ext = rd_word.d;
    endcase
  end

  always_ff @(posedge clk) begin
    if (rw_hs && !rw_write) begin
      load_q <= load_ext;
    end
  end

  assign mem_rd   = rd_q;
  assign mem_we   = !is_store;
  assign mem_data = (is_mem && !is_store) ? load_q : addr_q;

endmodule

//--- src/agu_stage.sv
`timescale 1ns/100ps

module agu_stage (
  input  logic                       clk,
  input  logic                       rst,

  input  logic                       issue_valid,
  input  lsu_pkg::mem_op_e           issue_op,
  input  logic [4:0]                 issue_rd,
  input  logic [lsu_pkg::xlen-1:0]   issue_base,
  input  logic [lsu_pkg::xlen-1:0]   issue_offset,
  input  logic [lsu_pkg::xlen-1:0]   issue_wdata,
  output logic                       issue_allowin,

  output logic                       agu_valid,
  output lsu_pkg::mem_op_e           agu_op,
  output logic [4:0]                 agu_rd,
  output logic [lsu_pkg::xlen-1:0]   agu_addr,
  output logic [lsu_pkg::xlen-1:0]   agu_wdata,
  input  logic                       mem_allowin
);

  import lsu_pkg::*;

  logic            valid_q;
  logic            accept;
  mem_op_e         op_q;
  logic [4:0]      rd_q;
  logic [xlen-1:0] addr_q;
  logic [xlen-1:0] wdata_q;

  // the address is ready as the item is latched, so the stage never waits.
  assign issue_allowin = !valid_q || mem_allowin;
  assign accept        = issue_valid && issue_allowin;

  always_ff @(posedge clk) begin
    if (rst) begin
      valid_q <= 1'b0;
    end else if (issue_allowin) begin
      valid_q <= issue_valid;
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      op_q    <= issue_op;
      rd_q    <= issue_rd;
      addr_q  <= issue_base + issue_offset;
      wdata_q <= issue_wdata;
    end
  end

  assign agu_valid = valid_q;
  assign agu_op    = op_q;
  assign agu_rd    = rd_q;
  assign agu_addr  = addr_q;
  assign agu_wdata = wdata_q;

endmodule

//--- src/lsu_pkg.sv
package lsu_pkg;

  // ********************
  // widths
  // ********************

  // data and address width.
  localparam int xlen = 64;

  // ********************
  // operation encodings
  // ********************

  typedef enum logic [3:0] {
    op_addr = 4'd0,
    op_lb   = 4'd1,
    op_lh   = 4'd2,
    op_lw   = 4'd3,
    op_ld   = 4'd4,
    op_lbu  = 4'd5,
    op_lhu  = 4'd6,
    op_lwu  = 4'd7,
    op_sb   = 4'd8,
    op_sh   = 4'd9,
    op_sw   = 4'd10,
    op_sd   = 4'd11
  } mem_op_e;

  typedef enum logic [1:0] {
    size_b = 2'd0,
    size_h = 2'd1,
    size_w = 2'd2,
    size_d = 2'd3
  } mem_size_e;

  // one ram word, seen as lanes of each access size.
  typedef union packed {
    logic [xlen-1:0]  d;
    logic [7:0][7:0]  b;
    logic [3:0][15:0] h;
    logic [1:0][31:0] w;
  } ram_word_u;

endpackage
